// File: rtl/conv_pkg.sv
package conv_pkg;

        // ==========================================================================
        // widths
        // ==========================================================================
        localparam int PIX_W       = 8;
        localparam int TAPS        = 9;
        localparam int IN_CH       = 4;
        localparam int MAC_LATENCY = 2;

        // derived widths
        localparam int WIN_W  = PIX_W * TAPS;
        localparam int PROD_W = 2 * PIX_W;
        localparam int SUM_W  = 24;
        localparam int ACC_W  = 32;

        // ==========================================================================
        // types
        // ==========================================================================
        typedef logic signed [PIX_W-1:0]  pixel_t;
        // tap k sits at bits 8k+7 down to 8k
        typedef logic        [WIN_W-1:0]  window_t;
        typedef logic signed [PROD_W-1:0] product_t;
        // 36 products of at most 16384 each fit in 24 bits
        typedef logic signed [SUM_W-1:0]  mac_sum_t;
        typedef logic signed [ACC_W-1:0]  acc_t;

        typedef enum logic [1:0] {
                BATCH_FIRST  = 2'd0,
                BATCH_MID    = 2'd1,
                BATCH_LAST   = 2'd2,
                BATCH_SINGLE = 2'd3
        } batch_t;

endpackage

// File: rtl/conv_window_mac.sv
module conv_window_mac (
        input  logic               sclk,
        input  logic               rst_n,
        input  conv_pkg::window_t  win0,
        input  conv_pkg::window_t  win1,
        input  conv_pkg::window_t  win2,
        input  conv_pkg::window_t  win3,
        input  conv_pkg::window_t  wgt0,
        input  conv_pkg::window_t  wgt1,
        input  conv_pkg::window_t  wgt2,
        input  conv_pkg::window_t  wgt3,
        output conv_pkg::mac_sum_t sum
);

        // ==========================================================================
        // internal signals
        // ==========================================================================
        conv_pkg::window_t  win_a  [conv_pkg::IN_CH];
        conv_pkg::window_t  wgt_a  [conv_pkg::IN_CH];
        conv_pkg::product_t prod_r [conv_pkg::IN_CH][conv_pkg::TAPS];
        conv_pkg::mac_sum_t total;

        assign win_a[0] = win0;
        assign win_a[1] = win1;
        assign win_a[2] = win2;
        assign win_a[3] = win3;

        assign wgt_a[0] = wgt0;
        assign wgt_a[1] = wgt1;
        assign wgt_a[2] = wgt2;
        assign wgt_a[3] = wgt3;

        // ==========================================================================
        // stage one, all 36 products
        // ==========================================================================
        always_ff @(posedge sclk) begin
                if (!rst_n) begin
                        for (int c = 0; c < conv_pkg::IN_CH; c++) begin
                                for (int k = 0; k < conv_pkg::TAPS; k++) begin
                                        prod_r[c][k] <= '0;
                                end
                        end
                end else begin
                        for (int c = 0; c < conv_pkg::IN_CH; c++) begin
                                for (int k = 0; k < conv_pkg::TAPS; k++) begin
                                        // both operands signed so the product is too
                                        prod_r[c][k] <=
                                                conv_pkg::pixel_t'(
                                                win_a[c][k*conv_pkg::PIX_W +: conv_pkg::PIX_W])
                                                * conv_pkg::pixel_t'(
                                                wgt_a[c][k*conv_pkg::PIX_W +: conv_pkg::PIX_W]);
                                end
                        end
                end
        end

        // ==========================================================================
        // stage two, adder tree
        // ==========================================================================
        always_comb begin
                total = '0;
                for (int c = 0; c < conv_pkg::IN_CH; c++) begin
                        for (int k = 0; k < conv_pkg::TAPS; k++) begin
                                // sign extend up to the sum width
                                total = total + conv_pkg::mac_sum_t'(prod_r[c][k]);
                        end
                end
        end

        always_ff @(posedge sclk) begin
                if (!rst_n) begin
                        sum <= '0;
                end else begin
                        sum <= total;
                end
        end

endmodule

// File: rtl/conv_batch_acc.sv
module conv_batch_acc (
        input  logic               sclk,
        input  logic               rst_n,
        input  logic               in_vld,
        input  conv_pkg::batch_t   batch_type,
        input  conv_pkg::mac_sum_t sum0,
        input  conv_pkg::mac_sum_t sum1,
        input  conv_pkg::acc_t     bias0,
        input  conv_pkg::acc_t     bias1,
        output conv_pkg::acc_t     out0,
        output conv_pkg::acc_t     out1,
        output logic               out_vld
);

        // ==========================================================================
        // internal signals
        // ==========================================================================
        logic [conv_pkg::MAC_LATENCY-1:0] vld_dly;
        conv_pkg::batch_t                 type_dly [conv_pkg::MAC_LATENCY];
        conv_pkg::acc_t                   bias_dly [conv_pkg::MAC_LATENCY][2];
        logic                             vld_al;
        conv_pkg::batch_t                 type_al;

        conv_pkg::acc_t sum_x  [2];
        conv_pkg::acc_t bias_a [2];
        conv_pkg::acc_t acc_r  [2];
        conv_pkg::acc_t out_r  [2];

        // sign extended MAC sums
        assign sum_x[0]  = conv_pkg::acc_t'(sum0);
        assign sum_x[1]  = conv_pkg::acc_t'(sum1);
        // bias travels with its beat
        assign bias_a[0] = bias_dly[conv_pkg::MAC_LATENCY-1][0];
        assign bias_a[1] = bias_dly[conv_pkg::MAC_LATENCY-1][1];

        assign out0 = out_r[0];
        assign out1 = out_r[1];

        // ==========================================================================
        // align valid, batch type and bias with the MAC pipeline
        // ==========================================================================
        always_ff @(posedge sclk) begin
                if (!rst_n) begin
                        vld_dly <= '0;
                        for (int d = 0; d < conv_pkg::MAC_LATENCY; d++) begin
                                type_dly[d]    <= conv_pkg::BATCH_FIRST;
                                bias_dly[d][0] <= '0;
                                bias_dly[d][1] <= '0;
                        end
                end else begin
                        vld_dly        <= {vld_dly[conv_pkg::MAC_LATENCY-2:0], in_vld};
                        type_dly[0]    <= batch_type;
                        bias_dly[0][0] <= bias0;
                        bias_dly[0][1] <= bias1;
                        for (int d = 1; d < conv_pkg::MAC_LATENCY; d++) begin
                                type_dly[d]    <= type_dly[d-1];
                                bias_dly[d][0] <= bias_dly[d-1][0];
                                bias_dly[d][1] <= bias_dly[d-1][1];
                        end
                end
        end

        assign vld_al  = vld_dly[conv_pkg::MAC_LATENCY-1];
        assign type_al = type_dly[conv_pkg::MAC_LATENCY-1];

        // ==========================================================================
        // accumulate across batches, add bias on the closing beat
        // ==========================================================================
        always_ff @(posedge sclk) begin
                if (!rst_n) begin
                        out_vld <= 1'b0;
                        for (int i = 0; i < 2; i++) begin
                                acc_r[i] <= '0;
                                out_r[i] <= '0;
                        end
                end else begin
                        out_vld <= vld_al && (type_al == conv_pkg::BATCH_LAST ||
                                              type_al == conv_pkg::BATCH_SINGLE);
                        if (vld_al) begin
                                for (int i = 0; i < 2; i++) begin
                                        case (type_al)
                                        conv_pkg::BATCH_FIRST: begin
                                                acc_r[i] <= sum_x[i];
                                        end
                                        conv_pkg::BATCH_MID: begin
                                                acc_r[i] <= acc_r[i] + sum_x[i];
                                        end
                                        conv_pkg::BATCH_LAST: begin
                                                out_r[i] <= acc_r[i] + sum_x[i] + bias_a[i];
                                                acc_r[i] <= '0;
                                        end
                                        conv_pkg::BATCH_SINGLE: begin
                                                // accumulator left alone
                                                out_r[i] <= sum_x[i] + bias_a[i];
                                        end
                                        endcase
                                end
                        end
                end
        end

endmodule

// File: rtl/conv_kernel_2ch.sv
module conv_kernel_2ch (
        input  logic              sclk,
        input  logic              rst_n,
        input  logic              in_vld,
        input  conv_pkg::batch_t  batch_type,
        // shared input windows
        input  conv_pkg::window_t win0,
        input  conv_pkg::window_t win1,
        input  conv_pkg::window_t win2,
        input  conv_pkg::window_t win3,
        // output channel 0 weights
        input  conv_pkg::window_t oc0_wgt0,
        input  conv_pkg::window_t oc0_wgt1,
        input  conv_pkg::window_t oc0_wgt2,
        input  conv_pkg::window_t oc0_wgt3,
        // output channel 1 weights
        input  conv_pkg::window_t oc1_wgt0,
        input  conv_pkg::window_t oc1_wgt1,
        input  conv_pkg::window_t oc1_wgt2,
        input  conv_pkg::window_t oc1_wgt3,
        input  conv_pkg::acc_t    oc0_bias,
        input  conv_pkg::acc_t    oc1_bias,
        output conv_pkg::acc_t    oc0_out,
        output conv_pkg::acc_t    oc1_out,
        output logic              out_vld
);

        // ==========================================================================
        // internal signals
        // ==========================================================================
        conv_pkg::mac_sum_t oc0_sum;
        conv_pkg::mac_sum_t oc1_sum;

        // ==========================================================================
        // per output channel MACs
        // ==========================================================================
        conv_window_mac u_mac_oc0 (
                .sclk  (sclk),
                .rst_n (rst_n),
                .win0  (win0),
                .win1  (win1),
                .win2  (win2),
                .win3  (win3),
                .wgt0  (oc0_wgt0),
                .wgt1  (oc0_wgt1),
                .wgt2  (oc0_wgt2),
                .wgt3  (oc0_wgt3),
                .sum   (oc0_sum)
        );

        conv_window_mac u_mac_oc1 (
                .sclk  (sclk),
                .rst_n (rst_n),
                .win0  (win0),
                .win1  (win1),
                .win2  (win2),
                .win3  (win3),
                .wgt0  (oc1_wgt0),
                .wgt1  (oc1_wgt1),
                .wgt2  (oc1_wgt2),
                .wgt3  (oc1_wgt3),
                .sum   (oc1_sum)
        );

        // ==========================================================================
        // batch accumulator
        // ==========================================================================
        // valid and batch type go in undelayed, alignment happens inside
        conv_batch_acc u_acc (
                .sclk       (sclk),
                .rst_n      (rst_n),
                .in_vld     (in_vld),
                .batch_type (batch_type),
                .sum0       (oc0_sum),
                .sum1       (oc1_sum),
                .bias0      (oc0_bias),
                .bias1      (oc1_bias),
                .out0       (oc0_out),
                .out1       (oc1_out),
                .out_vld    (out_vld)
        );

endmodule

// File: verif/conv_tb_vectors.svh
// columns: batch type (0 first, 1 mid, 2 last, 3 single), win0..win3 tap,
// oc0 wgt0..wgt3 tap, oc1 wgt0..wgt3 tap, oc0 bias, oc1 bias, expected oc0_out, oc1_out
// every tap of a window holds the same value, expected only used on last and single

localparam int NUM_ROWS = 14;

task automatic load_vectors();
        // single beat
        add_row(3,    1,    2,    3,    4,    1,    1,    1,    1,
                2,   -1,    0,    3,  100,  -50,  190,   58);
        // first, mid, mid, last with bias held
        add_row(0,    1,    1,    1,    1,    1,    1,    1,    1,
               -1,   -1,   -1,   -1, 1000,    7,    0,    0);
        add_row(1,    2,    0,    0,    0,    3,    0,    0,    0,
               -2,    0,    0,    0, 1000,    7,    0,    0);
        add_row(1,    0,    0,    0,   10,    0,    0,    0,   10,
                0,    0,    0,  -10, 1000,    7,    0,    0);
        add_row(2,   -1,   -1,   -1,   -1,    5,    5,    5,    5,
                1,    1,    1,    1, 1000,    7, 1810, -1001);
        // signed extremes
        add_row(3, -128, -128, -128, -128, -128, -128, -128, -128,
              127,  127,  127,  127,   -1, -100000, 589823, -685216);
        add_row(3,  127, -128,  127, -128,  127,  127, -128, -128,
             -128, -128, -128, -128, 32'h80000000, -5000, 32'h80000009, -2696);
        // singles followed by a short batch
        add_row(3,    3,    3,    3,    3,    1,    2,    3,    4,
               -1,    0,    0,    0,    0,    0,  270,  -27);
        add_row(0,    1,    2,    3,    4,    1,    0,    0,    0,
                0,    0,    0,    1,    5,   -5,    0,    0);
        add_row(2,    2,    2,    2,    2,   -1,   -1,   -1,   -1,
                4,    0,    0,    0,    5,   -5,  -58,  103);
        add_row(3,    0,    0,    0,    0,    1,    1,    1,    1,
                1,    1,    1,    1,   42,  -42,   42,  -42);
        // single inside a batch leaves the accumulator alone
        add_row(0,    1,    1,    1,    1,    2,    2,    2,    2,
                1,    1,    1,    1,   10,   20,    0,    0);
        add_row(3,    1,    0,    0,    0,   -3,    0,    0,    0,
                7,    0,    0,    0,   10,   20,  -17,   83);
        add_row(2,    1,    1,    1,    1,    1,    1,    1,    1,
               -1,   -1,   -1,   -1,   10,   20,  118,   20);
endtask

// File: verif/conv_kernel_2ch_tb.sv
module conv_kernel_2ch_tb;

        `include "conv_tb_vectors.svh"

        localparam int NUM_RAND        = 200;
        localparam int CLK_PERIOD      = 40;
        localparam int WATCHDOG_CYCLES = 16 + NUM_ROWS + NUM_RAND + 20;

        logic              sclk;
        logic              rst_n;
        logic              in_vld;
        conv_pkg::batch_t  batch_type;
        conv_pkg::window_t win     [4];
        conv_pkg::window_t oc0_wgt [4];
        conv_pkg::window_t oc1_wgt [4];
        conv_pkg::acc_t    oc0_bias;
        conv_pkg::acc_t    oc1_bias;
        conv_pkg::acc_t    oc0_out;
        conv_pkg::acc_t    oc1_out;
        logic              out_vld;

        // directed table
        int row_bt [NUM_ROWS];
        int row_x  [NUM_ROWS][4];
        int row_a  [NUM_ROWS][4];
        int row_c  [NUM_ROWS][4];
        int row_b0 [NUM_ROWS];
        int row_b1 [NUM_ROWS];
        int row_e0 [NUM_ROWS];
        int row_e1 [NUM_ROWS];
        int row_n = 0;

        int cyc = 0;
        int exp0_q [$];
        int exp1_q [$];
        int beat_cyc_q [$];
        int model_acc0 = 0;
        int model_acc1 = 0;

        conv_kernel_2ch dut0 (
                .sclk (sclk), .rst_n (rst_n), .in_vld (in_vld), .batch_type (batch_type),
                .win0 (win[0]), .win1 (win[1]), .win2 (win[2]), .win3 (win[3]),
                .oc0_wgt0 (oc0_wgt[0]), .oc0_wgt1 (oc0_wgt[1]),
                .oc0_wgt2 (oc0_wgt[2]), .oc0_wgt3 (oc0_wgt[3]),
                .oc1_wgt0 (oc1_wgt[0]), .oc1_wgt1 (oc1_wgt[1]),
                .oc1_wgt2 (oc1_wgt[2]), .oc1_wgt3 (oc1_wgt[3]),
                .oc0_bias (oc0_bias), .oc1_bias (oc1_bias),
                .oc0_out (oc0_out), .oc1_out (oc1_out), .out_vld (out_vld)
        );

        initial begin
                sclk = 1'b0;
                forever #(CLK_PERIOD / 2) sclk = ~sclk;
        end

        always @(posedge sclk) cyc <= cyc + 1;

        initial begin
                #(WATCHDOG_CYCLES * CLK_PERIOD);
                $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
                $display("=== FAIL ===");
                $fatal(1, "watchdog expired");
        end

        // ==========================================================================
        // checking helpers and reference model
        // ==========================================================================
        task automatic check_value(input string name, input logic signed [31:0] actual,
                                   input logic signed [31:0] expected);
                if (actual !== expected) begin
                        $display("FAILED time=%0t signal=%s actual=%0d expected=%0d",
                                 $time, name, actual, expected);
                        $display("=== FAIL ===");
                        $fatal(1, "value mismatch");
                end
        endtask

        task automatic report_failure(input string msg);
                $display("%s", msg);
                $display("=== FAIL ===");
                $fatal(1, "run stopped");
        endtask

        task automatic add_row(input int bt, input int x0, input int x1, input int x2,
                               input int x3, input int a0, input int a1, input int a2,
                               input int a3, input int c0, input int c1, input int c2,
                               input int c3, input int b0, input int b1, input int e0,
                               input int e1);
                row_bt[row_n] = bt;
                row_x[row_n]  = '{x0, x1, x2, x3};
                row_a[row_n]  = '{a0, a1, a2, a3};
                row_c[row_n]  = '{c0, c1, c2, c3};
                row_b0[row_n] = b0;
                row_b1[row_n] = b1;
                row_e0[row_n] = e0;
                row_e1[row_n] = e1;
                row_n++;
        endtask

        function automatic conv_pkg::window_t splat_window(input int v);
                return {9{v[7:0]}};
        endfunction

        function automatic conv_pkg::window_t random_window();
                return {$urandom, $urandom, 8'($urandom)};
        endfunction

        // nine taps times four input channels
        function automatic int channel_sum(input conv_pkg::window_t x [4],
                                           input conv_pkg::window_t w [4]);
                int total;
                total = 0;
                for (int c = 0; c < 4; c++) begin
                        for (int k = 0; k < 9; k++) begin
                                total += int'(conv_pkg::pixel_t'(x[c][8*k +: 8]))
                                         * int'(conv_pkg::pixel_t'(w[c][8*k +: 8]));
                        end
                end
                return total;
        endfunction

        task automatic expect_output(input int e0, input int e1);
                exp0_q.push_back(e0);
                exp1_q.push_back(e1);
                beat_cyc_q.push_back(cyc);
        endtask

        task automatic model_beat();
                int s0;
                int s1;
                s0 = channel_sum(win, oc0_wgt);
                s1 = channel_sum(win, oc1_wgt);
                case (batch_type)
                conv_pkg::BATCH_FIRST: begin
                        model_acc0 = s0;
                        model_acc1 = s1;
                end
                conv_pkg::BATCH_MID: begin
                        model_acc0 += s0;
                        model_acc1 += s1;
                end
                conv_pkg::BATCH_LAST: begin
                        expect_output(model_acc0 + s0 + oc0_bias, model_acc1 + s1 + oc1_bias);
                        model_acc0 = 0;
                        model_acc1 = 0;
                end
                conv_pkg::BATCH_SINGLE: begin
                        expect_output(s0 + oc0_bias, s1 + oc1_bias);
                end
                endcase
        endtask

        // ==========================================================================
        // stimulus
        // ==========================================================================
        initial begin
                int               waited;
                int               pick;
                bit               in_batch;
                conv_pkg::acc_t   batch_b0;
                conv_pkg::acc_t   batch_b1;
                void'($urandom(32'hbfba));
                rst_n      = 1'b0;
                in_vld     = 1'b0;
                batch_type = conv_pkg::BATCH_FIRST;
                for (int c = 0; c < 4; c++) begin
                        win[c]     = '0;
                        oc0_wgt[c] = '0;
                        oc1_wgt[c] = '0;
                end
                oc0_bias = '0;
                oc1_bias = '0;
                waited   = 0;
                in_batch = 1'b0;
                batch_b0 = '0;
                batch_b1 = '0;
                load_vectors();

                repeat (16) @(posedge sclk);
                #2 rst_n = 1'b1;
                // idle, nothing may come out
                repeat (4) @(posedge sclk);

                for (int r = 0; r < NUM_ROWS; r++) begin
                        @(posedge sclk);
                        #2;
                        in_vld     = 1'b1;
                        batch_type = conv_pkg::batch_t'(row_bt[r][1:0]);
                        for (int c = 0; c < 4; c++) begin
                                win[c]     = splat_window(row_x[r][c]);
                                oc0_wgt[c] = splat_window(row_a[r][c]);
                                oc1_wgt[c] = splat_window(row_c[r][c]);
                        end
                        oc0_bias = row_b0[r];
                        oc1_bias = row_b1[r];
                        if (batch_type == conv_pkg::BATCH_LAST ||
                            batch_type == conv_pkg::BATCH_SINGLE) begin
                                expect_output(row_e0[r], row_e1[r]);
                        end
                end

                // random beats, batches closed before the end
                for (int i = 0; i < NUM_RAND; i++) begin
                        @(posedge sclk);
                        #2;
                        pick = $urandom % 4;
                        if (i == NUM_RAND - 1) begin
                                batch_type = in_batch ? conv_pkg::BATCH_LAST
                                                      : conv_pkg::BATCH_SINGLE;
                        end else if (!in_batch) begin
                                batch_type = (pick < 2) ? conv_pkg::BATCH_SINGLE
                                                        : conv_pkg::BATCH_FIRST;
                        end else if (pick < 2) begin
                                batch_type = conv_pkg::BATCH_MID;
                        end else begin
                                batch_type = (pick == 2) ? conv_pkg::BATCH_LAST
                                                         : conv_pkg::BATCH_SINGLE;
                        end
                        if (batch_type == conv_pkg::BATCH_FIRST) begin
                                in_batch = 1'b1;
                                batch_b0 = $urandom;
                                batch_b1 = $urandom;
                        end else if (batch_type == conv_pkg::BATCH_LAST) begin
                                in_batch = 1'b0;
                        end
                        if (batch_type == conv_pkg::BATCH_SINGLE) begin
                                oc0_bias = $urandom;
                                oc1_bias = $urandom;
                        end else begin
                                oc0_bias = batch_b0;
                                oc1_bias = batch_b1;
                        end
                        for (int c = 0; c < 4; c++) begin
                                win[c]     = random_window();
                                oc0_wgt[c] = random_window();
                                oc1_wgt[c] = random_window();
                        end
                        in_vld = 1'b1;
                        model_beat();
                end
                @(posedge sclk);
                #2 in_vld = 1'b0;

                while (exp0_q.size() != 0 && waited < 10) begin
                        @(posedge sclk);
                        waited++;
                end
                repeat (4) @(posedge sclk);
                if (exp0_q.size() != 0) begin
                        $display("%0d expected outputs never appeared", exp0_q.size());
                        $display("=== FAIL ===");
                        $fatal(1, "missing outputs");
                end else begin
                        $display("=== PASS ===");
                        $finish;
                end
        end

        // ==========================================================================
        // output monitor
        // ==========================================================================
        always @(negedge sclk) begin
                if (!rst_n) begin
                        if (cyc > 0) begin
                                check_value("out_vld", 32'(out_vld), 32'd0);
                        end
                end else if (out_vld) begin
                        if (exp0_q.size() == 0) begin
                                report_failure("out_vld went high with no output expected");
                        end else begin
                                check_value("oc0_out", oc0_out, exp0_q.pop_front());
                                check_value("oc1_out", oc1_out, exp1_q.pop_front());
                                check_value("out_vld latency", cyc - beat_cyc_q.pop_front(), 3);
                        end
                end
        end

endmodule

// File: conv_kernel_2ch.f
+incdir+verif
rtl/conv_pkg.sv
rtl/conv_window_mac.sv
rtl/conv_batch_acc.sv
rtl/conv_kernel_2ch.sv
verif/conv_kernel_2ch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass only if the pass line shows up

cd "$(dirname "$0")" &&
verilator --binary --timing \
        -f conv_kernel_2ch.f \
        --top-module conv_kernel_2ch_tb \
        --Mdir obj_dir -o conv_kernel_2ch_sim &&
./obj_dir/conv_kernel_2ch_sim | tee /dev/stderr | grep -x "=== PASS ===" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
